// File: breakout_title.f
hdl/breakout_title_pkg.sv
hdl/title_glyph_rom.sv
hdl/title_text_renderer.sv
hdl/ball_motion.sv
hdl/ball_renderer.sv
hdl/title_compositor.sv
hdl/breakout_title_top.sv
dv/tb_clock_gen.sv
dv/breakout_title_tb.sv

// File: dv/breakout_title_tb.sv
module breakout_title_tb
   import breakout_title_pkg::*;
();

   localparam int RESET_TIMEOUT = 20;

   logic   clk;
   logic   reset;
   logic   frame_tick;
   logic   start_button;
   coord_t pix_x;
   coord_t pix_y;
   logic   pixel_on;
   rgb_t   pixel_rgb;
   logic   title_screen;
   logic   start_game;

   int     test_errors;
   int     pass_count;
   int     fail_count;
   bit     timed_out;
   bit     reset_done;
   // Expected ball origin, advanced by one step per tick
   int     ref_x;
   int     ref_y;

   tb_clock_gen i_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   breakout_title_top i_dut (
      .clk          (clk),
      .reset        (reset),
      .frame_tick   (frame_tick),
      .start_button (start_button),
      .pix_x        (pix_x),
      .pix_y        (pix_y),
      .pixel_on     (pixel_on),
      .pixel_rgb    (pixel_rgb),
      .title_screen (title_screen),
      .start_game   (start_game)
   );

   // -------------------------------------------------------------------
   // Helpers
   // -------------------------------------------------------------------
   task automatic wait_reset_release(output bit ok);
      int cycles;
      ok = 1'b0;
      for (cycles = 0; (cycles < RESET_TIMEOUT) && !ok; cycles++) begin
         @(negedge clk);
         #1;
         if (!reset) begin
            ok = 1'b1;
         end
      end
   endtask

   // Pixel set on the falling edge, sampled once settled
   task automatic expect_pixel(input int x, input int y, input logic exp_on,
                               input rgb_t exp_rgb, input string what);
      @(negedge clk);
      pix_x = coord_t'(x);
      pix_y = coord_t'(y);
      #1;
      assert (pixel_on === exp_on) else begin
         $display("Error: time %0t, %s at %0d,%0d: pixel_on is %b, expected %b",
                  $time, what, x, y, pixel_on, exp_on);
         test_errors++;
      end
      assert (pixel_rgb === exp_rgb) else begin
         $display("Error: time %0t, %s at %0d,%0d: colour is %h, expected %h",
                  $time, what, x, y, pixel_rgb, exp_rgb);
         test_errors++;
      end
   endtask

   task automatic expect_title(input logic exp_title, input logic exp_start,
                               input string what);
      assert (title_screen === exp_title) else begin
         $display("Error: time %0t, %s: title_screen is %b, expected %b",
                  $time, what, title_screen, exp_title);
         test_errors++;
      end
      assert (start_game === exp_start) else begin
         $display("Error: time %0t, %s: start_game is %b, expected %b",
                  $time, what, start_game, exp_start);
         test_errors++;
      end
   endtask

   // One clock of frame_tick, ball moves without bouncing
   task automatic pulse_frame_tick();
      @(negedge clk);
      frame_tick = 1'b1;
      @(negedge clk);
      frame_tick = 1'b0;
      ref_x = ref_x + int'(BALL_SPEED);
      ref_y = ref_y + int'(BALL_SPEED);
   endtask

   // Drives start_button high for a single cycle
   task automatic press_start(input logic exp_start, input string what);
      @(negedge clk);
      start_button = 1'b1;
      #1;
      expect_title(exp_start, exp_start, what);
      @(negedge clk);
      start_button = 1'b0;
      #1;
      expect_title(1'b0, 1'b0, {what, " after the edge"});
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         $display("%-18s ok", name);
         pass_count++;
      end else begin
         $display("%-18s failed, %0d check(s)", name, test_errors);
         fail_count++;
      end
      test_errors = 0;
   endtask

   // -------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------
   initial begin
      frame_tick   = 1'b0;
      start_button = 1'b0;
      pix_x        = '0;
      pix_y        = '0;
      test_errors  = 0;
      pass_count   = 0;
      fail_count   = 0;
      timed_out    = 1'b0;
      ref_x        = int'(BALL_X0);
      ref_y        = int'(BALL_Y0);

      wait_reset_release(reset_done);
      if (!reset_done) begin
         $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
         timed_out = 1'b1;
      end else begin
         expect_title(1'b1, 1'b0, "after reset");
         finish_test("reset_state");

         // B and T both start with a set pixel, B row 0 column 10 is clear
         expect_pixel(230, 240, 1'b1, LETTER_RGB, "B row 0 col 0");
         expect_pixel(240, 240, 1'b0, BG_RGB, "B row 0 col 10");
         expect_pixel(384, 240, 1'b1, LETTER_RGB, "T row 0 col 0");
         finish_test("letters");

         expect_pixel(300, 275, 1'b1, PADDLE_RGB, "paddle");
         expect_pixel(500, 400, 1'b0, BG_RGB, "background");
         finish_test("paddle_background");

         expect_pixel(ref_x + 3, ref_y + 3, 1'b1, BALL_RGB, "ball centre");
         expect_pixel(ref_x, ref_y, 1'b0, BG_RGB, "ball corner");
         finish_test("ball_shape");

         repeat (5) pulse_frame_tick();
         expect_pixel(ref_x + 3, ref_y + 3, 1'b1, BALL_RGB, "moved ball centre");
         expect_pixel(int'(BALL_X0) + 3, int'(BALL_Y0) + 3, 1'b0, BG_RGB, "old ball spot");
         finish_test("ball_motion");

         press_start(1'b1, "first press");
         // Title is gone, so the second press stays silent
         press_start(1'b0, "second press");
         finish_test("start");
      end

      $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
      if ((fail_count == 0) && !timed_out) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen (
   output logic clk,
   output logic reset
);

   // 8 unit period
   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   // Held over three rising edges, released on a falling edge
   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// File: hdl/breakout_title_top.sv
module breakout_title_top
   import breakout_title_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        frame_tick,
   input  logic        start_button,
   input  logic [11:0] pix_x,
   input  logic [11:0] pix_y,
   output logic        pixel_on,
   output logic [23:0] pixel_rgb,
   output logic        title_screen,
   output logic        start_game
);

   logic   letter_hit;
   logic   ball_hit;
   coord_t ball_x;
   coord_t ball_y;

   // Word BREAKOUT
   title_text_renderer i_text (
      .pix_x      (pix_x),
      .pix_y      (pix_y),
      .letter_hit (letter_hit)
   );

   // Bouncing ball
   ball_motion i_ball_motion (
      .clk        (clk),
      .reset      (reset),
      .frame_tick (frame_tick),
      .ball_x     (ball_x),
      .ball_y     (ball_y)
   );

   ball_renderer i_ball_render (
      .pix_x    (pix_x),
      .pix_y    (pix_y),
      .ball_x   (ball_x),
      .ball_y   (ball_y),
      .ball_hit (ball_hit)
   );

   // Paddle, layer merge and title state
   title_compositor i_compositor (
      .clk          (clk),
      .reset        (reset),
      .start_button (start_button),
      .letter_hit   (letter_hit),
      .ball_hit     (ball_hit),
      .pix_x        (pix_x),
      .pix_y        (pix_y),
      .pixel_on     (pixel_on),
      .pixel_rgb    (pixel_rgb),
      .title_screen (title_screen),
      .start_game   (start_game)
   );

endmodule

// File: hdl/title_compositor.sv
module title_compositor
   import breakout_title_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   start_button,
   input  logic   letter_hit,
   input  logic   ball_hit,
   input  coord_t pix_x,
   input  coord_t pix_y,
   output logic   pixel_on,
   output rgb_t   pixel_rgb,
   output logic   title_screen,
   output logic   start_game
);

   title_state_e state;
   logic         paddle_hit;

   // -------------------------------------------------------------------
   // Pixel layers
   // -------------------------------------------------------------------
   assign paddle_hit = (pix_x >= PADDLE_X_L) && (pix_x < PADDLE_X_L + PADDLE_W) &&
                       (pix_y >= PADDLE_Y_T) && (pix_y <= PADDLE_Y_B);

   assign pixel_on = letter_hit || ball_hit || paddle_hit;

   // Letters on top, paddle at the bottom
   always_comb begin
      if (letter_hit) begin
         pixel_rgb = LETTER_RGB;
      end else if (ball_hit) begin
         pixel_rgb = BALL_RGB;
      end else if (paddle_hit) begin
         pixel_rgb = PADDLE_RGB;
      end else begin
         pixel_rgb = BG_RGB;
      end
   end

   // -------------------------------------------------------------------
   // Title state
   // -------------------------------------------------------------------

   // Leaves the title once, stays done until reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= TITLE_SHOW;
      end else if ((state == TITLE_SHOW) && start_button) begin
         state <= TITLE_DONE;
      end
   end

   assign title_screen = (state == TITLE_SHOW);
   assign start_game   = title_screen && start_button;

endmodule

// File: hdl/ball_renderer.sv
module ball_renderer
   import breakout_title_pkg::*;
(
   input  coord_t pix_x,
   input  coord_t pix_y,
   input  coord_t ball_x,
   input  coord_t ball_y,
   output logic   ball_hit
);

   logic       in_box;
   logic [2:0] row;
   logic [2:0] col;
   logic [7:0] shape;

   // Pixel inside the square box of the ball
   assign in_box = (pix_x >= ball_x) && (pix_x < ball_x + BALL_SIZE) &&
                   (pix_y >= ball_y) && (pix_y < ball_y + BALL_SIZE);

   // Offsets within the box, only meaningful when in_box is set
   assign row = 3'(pix_y - ball_y);
   assign col = 3'(pix_x - ball_x);

   // Round ball, corners cut off
   always_comb begin
      case (row)
         3'd0:       shape = 8'h3C;
         3'd1:       shape = 8'h7E;
         3'd2, 3'd3,
         3'd4, 3'd5: shape = 8'hFF;
         3'd6:       shape = 8'h7E;
         default:    shape = 8'h3C;
      endcase
   end

   // Bit 0 is the leftmost column
   assign ball_hit = in_box && shape[col];

endmodule

// File: hdl/ball_motion.sv
module ball_motion
   import breakout_title_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   frame_tick,
   output coord_t ball_x,
   output coord_t ball_y
);

   velocity_t dx;
   velocity_t dy;
   velocity_t dx_next;
   velocity_t dy_next;
   coord_t    ball_x_r;
   coord_t    ball_y_b;
   logic      on_paddle;

   // Right and bottom edges of the ball box
   assign ball_x_r = ball_x + BALL_SIZE - 12'd1;
   assign ball_y_b = ball_y + BALL_SIZE - 12'd1;

   // Bottom edge resting on the paddle top rows, fully inside its span
   assign on_paddle = (ball_y_b >= PADDLE_Y_T - 12'd1) &&
                      (ball_y_b <= PADDLE_Y_B - 12'd1) &&
                      (ball_x >= PADDLE_X_L) &&
                      (ball_x_r < PADDLE_X_L + PADDLE_W);

   // -------------------------------------------------------------------
   // Bounce decisions, first match wins
   // -------------------------------------------------------------------
   always_comb begin
      dx_next = dx;
      dy_next = dy;
      if (ball_y <= EDGE_MARGIN_TOP) begin
         dy_next = BALL_SPEED;
      end else if (ball_y_b >= SCREEN_H - 12'd2) begin
         dy_next = -BALL_SPEED;
      end else if (on_paddle) begin
         dy_next = -BALL_SPEED;
      end else if (ball_x_r > SCREEN_W - 12'd1) begin
         dx_next = -BALL_SPEED;
      end else if (ball_x <= EDGE_MARGIN_LEFT) begin
         dx_next = BALL_SPEED;
      end
   end

   // -------------------------------------------------------------------
   // Position and velocity registers
   // -------------------------------------------------------------------

   // Velocity follows the bounce logic every clock
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         dx <= BALL_SPEED;
         dy <= BALL_SPEED;
      end else begin
         dx <= dx_next;
         dy <= dy_next;
      end
   end

   // One step per frame
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ball_x <= BALL_X0;
         ball_y <= BALL_Y0;
      end else if (frame_tick) begin
         ball_x <= ball_x + coord_t'(dx);
         ball_y <= ball_y + coord_t'(dy);
      end
   end

endmodule

// File: hdl/title_text_renderer.sv
module title_text_renderer
   import breakout_title_pkg::*;
(
   input  coord_t pix_x,
   input  coord_t pix_y,
   output logic   letter_hit
);

   logic       in_slot;
   logic       in_row;
   letter_e    slot_letter;
   logic [3:0] col;
   logic [4:0] row;
   glyph_row_t row_bits;

   // Left edge of letter slot n
   function automatic coord_t slot_left(input int n);
      return LETTER_X0 + coord_t'(n) * LETTER_PITCH;
   endfunction

   // -------------------------------------------------------------------
   // Slot search
   // -------------------------------------------------------------------

   // Slots never overlap, so at most one matches
   always_comb begin
      in_slot     = 1'b0;
      slot_letter = B;
      col         = '0;
      for (int n = 0; n < NUM_LETTERS; n++) begin
         if ((pix_x >= slot_left(n)) && (pix_x < slot_left(n) + LETTER_W)) begin
            in_slot     = 1'b1;
            slot_letter = letter_e'(n);
            col         = 4'(pix_x - slot_left(n));
         end
      end
   end

   // All letters share one baseline
   assign in_row = (pix_y >= LETTER_Y0) && (pix_y < LETTER_Y0 + LETTER_H);
   assign row    = 5'(pix_y - LETTER_Y0);

   // -------------------------------------------------------------------
   // Bitmap lookup
   // -------------------------------------------------------------------
   title_glyph_rom i_glyph_rom (
      .letter (slot_letter),
      .row    (row),
      .bits   (row_bits)
   );

   assign letter_hit = in_slot && in_row && row_bits[col];

endmodule

// File: hdl/title_glyph_rom.sv
module title_glyph_rom
   import breakout_title_pkg::*;
(
   input  letter_e    letter,
   input  logic [4:0] row,
   output glyph_row_t bits
);

   // Whole bitmap of the selected letter, row 0 at the top end
   logic [LETTER_H*LETTER_W-1:0] glyph;
   // Row as drawn, leftmost pixel in the MSB
   glyph_row_t                   drawn;
   logic [8:0]                   base;

   // Rows are written as drawn on screen, four to a line
   always_comb begin
      glyph = '0;
      case (letter)
         B: glyph = {16'hFFC0, 16'hFFE0, 16'hC070, 16'hC030,
                     16'hC030, 16'hC030, 16'hC030, 16'hC070,
                     16'hFFC0, 16'hFFE0, 16'hC030, 16'hC018,
                     16'hC018, 16'hC018, 16'hC018, 16'hC038,
                     16'hFFF0, 16'h0000};
         R: glyph = {16'hFFE0, 16'hFFF8, 16'hC01C, 16'hC00C,
                     16'hC00C, 16'hC00C, 16'hC01C, 16'hC038,
                     16'hFFF0, 16'hFFC0, 16'hC0E0, 16'hC060,
                     16'hC070, 16'hC038, 16'hC01C, 16'hC01C,
                     16'hC00E, 16'h0000};
         E: glyph = {16'hFFF0, 16'h3010, 16'h3000, 16'h3000,
                     16'h3000, 16'h3000, 16'h3020, 16'h3020,
                     16'h3FE0, 16'h3020, 16'h3000, 16'h3000,
                     16'h3000, 16'h3000, 16'h3010, 16'hFFF0,
                     16'h0000, 16'h0000};
         A: glyph = {16'h00C0, 16'h00C0, 16'h01E0, 16'h01E0,
                     16'h0360, 16'h0270, 16'h0230, 16'h0438,
                     16'h0418, 16'h0C1C, 16'h0FFC, 16'h180C,
                     16'h100E, 16'h3006, 16'h3007, 16'hF81F,
                     16'h0000, 16'h0000};
         K: glyph = {16'hFC7E, 16'h7038, 16'h3030, 16'h3060,
                     16'h30C0, 16'h3180, 16'h3300, 16'h3600,
                     16'h3E00, 16'h3700, 16'h3380, 16'h31C0,
                     16'h30F0, 16'h3078, 16'h303C, 16'h701E,
                     16'hFC7F, 16'h0000};
         O: glyph = {16'h07E0, 16'h1C38, 16'h300C, 16'h700E,
                     16'h6006, 16'hE007, 16'hE007, 16'hE007,
                     16'hE007, 16'hE007, 16'hE007, 16'hE007,
                     16'h6006, 16'h700E, 16'h300C, 16'h1C38,
                     16'h07E0, 16'h0000};
         U: glyph = {16'h7E0F, 16'h3803, 16'h1802, 16'h1802,
                     16'h1802, 16'h1802, 16'h1802, 16'h1802,
                     16'h1802, 16'h1802, 16'h1802, 16'h1802,
                     16'h1802, 16'h1802, 16'h1C04, 16'h0E0C,
                     16'h03F0, 16'h0000};
         T: glyph = {16'hFFF8, 16'h8308, 16'h0304, 16'h0300,
                     16'h0300, 16'h0300, 16'h0300, 16'h0300,
                     16'h0300, 16'h0300, 16'h0300, 16'h0300,
                     16'h0300, 16'h0300, 16'h0300, 16'h0700,
                     16'h1FC0, 16'h0000};
      endcase
   end

   // Row 0 sits in the top word of the concatenation
   assign base = 9'((LETTER_H - 12'd1 - coord_t'(row)) * LETTER_W);

   always_comb begin
      drawn = '0;
      if (coord_t'(row) < LETTER_H) begin
         drawn = glyph[base +: LETTER_W];
      end
   end

   // Flip so that bit 0 is the leftmost pixel
   assign bits = {<<{drawn}};

endmodule

// File: hdl/breakout_title_pkg.sv
package breakout_title_pkg;

   // -------------------------------------------------------------------
   // Types
   // -------------------------------------------------------------------

   // Screen coordinate, wide enough for either axis
   typedef logic [11:0] coord_t;

   // Ball step per frame, two's complement
   typedef logic signed [11:0] velocity_t;

   typedef logic [23:0] rgb_t;

   // One letter row, bit 0 is the leftmost pixel
   typedef logic [15:0] glyph_row_t;

   // Letters in the order they appear in the word
   typedef enum logic [2:0] {
      B = 3'd0,
      R = 3'd1,
      E = 3'd2,
      A = 3'd3,
      K = 3'd4,
      O = 3'd5,
      U = 3'd6,
      T = 3'd7
   } letter_e;

   typedef enum logic {
      TITLE_SHOW = 1'b0,
      TITLE_DONE = 1'b1
   } title_state_e;

   // -------------------------------------------------------------------
   // Screen
   // -------------------------------------------------------------------
   localparam coord_t SCREEN_W         = 12'd640;
   localparam coord_t SCREEN_H         = 12'd480;
   localparam coord_t EDGE_MARGIN_TOP  = 12'd2;
   localparam coord_t EDGE_MARGIN_LEFT = 12'd1;

   // -------------------------------------------------------------------
   // Title letters
   // -------------------------------------------------------------------
   localparam int     NUM_LETTERS  = 8;
   localparam coord_t LETTER_W     = 12'd16;
   localparam coord_t LETTER_H     = 12'd18;
   // Origin of the B, the others follow at a fixed pitch
   localparam coord_t LETTER_X0    = 12'd230;
   localparam coord_t LETTER_PITCH = 12'd22;
   localparam coord_t LETTER_Y0    = 12'd240;

   // -------------------------------------------------------------------
   // Ball and paddle
   // -------------------------------------------------------------------
   localparam coord_t    BALL_SIZE  = 12'd8;
   localparam coord_t    BALL_X0    = 12'd60;
   localparam coord_t    BALL_Y0    = 12'd170;
   localparam velocity_t BALL_SPEED = 12'sd4;

   localparam coord_t PADDLE_X_L = 12'd230;
   localparam coord_t PADDLE_W   = 12'd170;
   // Both rows inclusive
   localparam coord_t PADDLE_Y_T = 12'd270;
   localparam coord_t PADDLE_Y_B = 12'd280;

   // -------------------------------------------------------------------
   // Colours
   // -------------------------------------------------------------------
   localparam rgb_t LETTER_RGB = 24'h7F00FF;
   localparam rgb_t BALL_RGB   = 24'hFFDE00;
   localparam rgb_t PADDLE_RGB = 24'h00FF33;
   localparam rgb_t BG_RGB     = 24'h000000;

endpackage
